/* Bender.yml */
package:
  name: decode_stage

sources:
  - files:
      - wiscIsaPkg.sv
      - decodeCtrlPkg.sv
      - controlDecoder.sv
      - immediateExtender.sv
      - regFile.sv
      - decodeStage.sv
  - target: test
    files:
      - decodeStageTb.sv

/* controlDecoder.sv */
// purely combinational, halt comes from the opcode alone and unlisted opcodes leave all controls low
`timescale 1ns/1ps

module controlDecoder
   import wiscIsaPkg::*;
   import decodeCtrlPkg::*;
(
   input  instr_t     instruction,
   output logic       regWrt,
   output logic       invA,
   output logic       invB,
   output logic       memWrt,
   output logic       memRd,
   output logic       aluJmp,
   output logic       pcOrAdd,
   output logic       slbi,
   output logic       btr,
   output logic       branching,
   output logic       halt,
   output aluOpr_t    aluOpr,
   output bSrc_t      bSrc,
   output regSrc_t    regSrc,
   output branchCmd_t branchCommand,
   output setCtrl_t   setCtrl,
   output regIdx_t    writeRegOut,
   output logic       zeroExt        // to the immediate extender
);

   opcode_t opcode;
   regDst_t regDst;                  // internal, only steers writeRegOut

   assign opcode = instruction[15:11];

   always_comb begin
      regWrt        = 1'b0;          // everything low unless the opcode says otherwise
      invA          = 1'b0;
      invB          = 1'b0;
      memWrt        = 1'b0;
      memRd         = 1'b0;
      aluJmp        = 1'b0;
      pcOrAdd       = 1'b0;
      slbi          = 1'b0;
      btr           = 1'b0;
      branching     = 1'b0;
      halt          = 1'b0;
      zeroExt       = 1'b0;
      aluOpr        = aluRol;
      bSrc          = bSrcReg;
      regSrc        = srcPc;
      regDst        = dstRt;
      branchCommand = brEqz;
      setCtrl       = setNone;
      case (opcode)
         opHalt: halt = 1'b1;
         opNop: ;                                   // no control raised
         opAddi, opSubi, opXori, opAndni: begin
            regWrt = 1'b1;                          // rd in bits 7..5
            bSrc   = bSrcImm5;
            regSrc = srcAlu;
            case (opcode)
               opAddi: aluOpr = aluAdd;
               opSubi: begin
                  aluOpr = aluAdd;                  // imm - rs as ~rs + 1 + imm
                  invA   = 1'b1;
               end
               opXori: begin
                  aluOpr  = aluXor;
                  zeroExt = 1'b1;
               end
               default: begin                       // andni
                  aluOpr  = aluAnd;
                  invB    = 1'b1;
                  zeroExt = 1'b1;
               end
            endcase
         end
         opRoli, opSlli, opRori, opSrli: begin
            regWrt = 1'b1;
            bSrc   = bSrcImm5;                      // alu uses low 4 bits as the amount
            regSrc = srcAlu;
            case (opcode)
               opRoli:  aluOpr = aluRol;
               opSlli:  aluOpr = aluSll;
               opRori:  aluOpr = aluRor;
               default: aluOpr = aluSrl;
            endcase
         end
         opSt: begin
            memWrt = 1'b1;                          // address rs + imm5, data from rd
            bSrc   = bSrcImm5;
            aluOpr = aluAdd;
         end
         opLd: begin
            memRd  = 1'b1;
            regWrt = 1'b1;
            bSrc   = bSrcImm5;
            regSrc = srcMem;
            aluOpr = aluAdd;
         end
         opStu: begin
            memWrt = 1'b1;
            regWrt = 1'b1;                          // effective address back into rs
            bSrc   = bSrcImm5;
            regSrc = srcAlu;
            regDst = dstRs;
            aluOpr = aluAdd;
         end
         opSlbi: begin
            slbi    = 1'b1;                         // alu shifts rs by 8 before the or
            aluOpr  = aluOr;
            bSrc    = bSrcImm8;
            regDst  = dstRs;
            zeroExt = 1'b1;
            regSrc  = srcAlu;
            regWrt  = 1'b1;
         end
         opLbi: begin
            regWrt = 1'b1;
            regDst = dstRs;
            bSrc   = bSrcImm8;                      // sign-extended imm8
            regSrc = srcImm;
         end
         opBtr: begin
            btr    = 1'b1;                          // bit reverse of rs
            regWrt = 1'b1;
            regDst = dstRd;
            regSrc = srcAlu;
         end
         opArith, opShift: begin
            regWrt = 1'b1;
            regDst = dstRd;
            regSrc = srcAlu;
            case ({opcode[0], instruction[1:0]})    // funct picks the op
               3'b100: aluOpr = aluAdd;
               3'b101: begin
                  aluOpr = aluAdd;                  // rt - rs
                  invA   = 1'b1;
               end
               3'b110: aluOpr = aluXor;
               3'b111: begin
                  aluOpr = aluAnd;                  // rs & ~rt
                  invB   = 1'b1;
               end
               3'b000: aluOpr = aluRol;
               3'b001: aluOpr = aluSll;
               3'b010: aluOpr = aluRor;
               default: aluOpr = aluSrl;
            endcase
         end
         opSeq, opSlt, opSle, opSco: begin
            regWrt = 1'b1;
            regSrc = srcAlu;
            regDst = dstRd;
            case (opcode)
               opSeq:   setCtrl = setSeq;
               opSlt:   setCtrl = setSlt;
               opSle:   setCtrl = setSle;
               default: setCtrl = setSco;
            endcase
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            branching = 1'b1;
            aluOpr    = aluAdd;                     // pc + 2 + imm8 target
            case (opcode)
               opBeqz: branchCommand = brEqz;
               opBnez: branchCommand = brNez;
               opBltz: begin
                  branchCommand = brLtz;
                  invB          = 1'b1;
               end
               default: begin
                  branchCommand = brGez;
                  invB          = 1'b1;
               end
            endcase
         end
         opJ: begin
            aluOpr  = aluAdd;
            pcOrAdd = 1'b1;                         // pc + 2 + 11-bit displacement
         end
         opJr: begin
            aluOpr = aluAdd;
            bSrc   = bSrcImm8;
            aluJmp = 1'b1;                          // target is rs + imm8 from the alu
         end
         opJal: begin
            aluOpr  = aluAdd;
            pcOrAdd = 1'b1;
            regWrt  = 1'b1;                         // regSrc stays pc for the link value
            regDst  = dstLink;
         end
         opJalr: begin
            aluOpr = aluAdd;
            bSrc   = bSrcImm8;
            aluJmp = 1'b1;
            regWrt = 1'b1;
            regDst = dstLink;
         end
         default: ;                                 // 00010 and 00011 act as nop
      endcase
   end

   always_comb begin
      case (regDst)
         dstRt:   writeRegOut = instruction[7:5];
         dstRs:   writeRegOut = instruction[10:8];
         dstRd:   writeRegOut = instruction[4:2];
         default: writeRegOut = linkReg;
      endcase
   end

   // checked on every instruction change against the settled outputs of the previous one
   memExclusive: assert property (@(instruction) memRd |-> !memWrt)
      else $error("memRd and memWrt high together");
   branchNoWrite: assert property (@(instruction) branching |-> !regWrt)
      else $error("branch decoded with a register write");

endmodule

/* decodeCtrlPkg.sv */
// control field encodings shared by decode and the later stages that consume them
package decodeCtrlPkg;

   typedef logic [2:0] aluOpr_t;    // alu operation select
   typedef logic [1:0] bSrc_t;      // alu b operand source
   typedef logic [1:0] regDst_t;    // write register field select
   typedef logic [1:0] regSrc_t;    // writeback mux select
   typedef logic [1:0] branchCmd_t; // branch condition on rs
   typedef logic [2:0] setCtrl_t;   // set-on-compare select

   // alu operations, upper bit splits shift/rotate from arithmetic/logic
   localparam aluOpr_t aluRol = 3'b000;
   localparam aluOpr_t aluSll = 3'b001;
   localparam aluOpr_t aluRor = 3'b010;
   localparam aluOpr_t aluSrl = 3'b011;
   localparam aluOpr_t aluAdd = 3'b100;
   localparam aluOpr_t aluAnd = 3'b101;
   localparam aluOpr_t aluOr  = 3'b110;
   localparam aluOpr_t aluXor = 3'b111;

   localparam bSrc_t bSrcReg  = 2'b00;            // rt from read port 2
   localparam bSrc_t bSrcImm5 = 2'b01;            // extended bits 4..0
   localparam bSrc_t bSrcImm8 = 2'b10;            // extended bits 7..0

   localparam regDst_t dstRt   = 2'b00;           // bits 7..5
   localparam regDst_t dstRs   = 2'b01;           // bits 10..8
   localparam regDst_t dstRd   = 2'b10;           // bits 4..2
   localparam regDst_t dstLink = 2'b11;           // fixed r7

   localparam regSrc_t srcPc  = 2'b00;            // pc + 2 for link
   localparam regSrc_t srcMem = 2'b01;
   localparam regSrc_t srcAlu = 2'b10;
   localparam regSrc_t srcImm = 2'b11;            // imm8 straight through

   localparam branchCmd_t brEqz = 2'b00;
   localparam branchCmd_t brNez = 2'b01;
   localparam branchCmd_t brLtz = 2'b10;
   localparam branchCmd_t brGez = 2'b11;

   // msb marks a compare, low bits pick the test
   localparam setCtrl_t setNone = 3'b000;
   localparam setCtrl_t setSeq  = 3'b100;
   localparam setCtrl_t setSlt  = 3'b101;
   localparam setCtrl_t setSle  = 3'b110;
   localparam setCtrl_t setSco  = 3'b111;

endpackage

/* decodeStage.sv */
// decode stage without fetch halt or stall, accepts one instruction every cycle with zero latency
`timescale 1ns/1ps

module decodeStage
   import wiscIsaPkg::*;
   import decodeCtrlPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  instr_t     instruction,
   input  word_t      writeData,      // writeback value
   input  regIdx_t    writeRegFromWb,
   input  logic       regWrtFromWb,
   output word_t      readData1,
   output word_t      readData2,
   output word_t      imm1,
   output word_t      imm2,
   output word_t      wordAlignJump,
   output regIdx_t    writeRegOut,    // destination carried down the pipe
   output aluOpr_t    aluOpr,
   output bSrc_t      bSrc,
   output regSrc_t    regSrc,
   output branchCmd_t branchCommand,
   output setCtrl_t   setCtrl,
   output logic       regWrt,
   output logic       invA,
   output logic       invB,
   output logic       memWrt,
   output logic       memRd,
   output logic       aluJmp,
   output logic       pcOrAdd,
   output logic       slbi,
   output logic       btr,
   output logic       branching,
   output logic       halt
);

   logic zeroExt;                     // decoder to extender

   controlDecoder u_controlDecoder (
      .instruction  (instruction),
      .regWrt       (regWrt),
      .invA         (invA),
      .invB         (invB),
      .memWrt       (memWrt),
      .memRd        (memRd),
      .aluJmp       (aluJmp),
      .pcOrAdd      (pcOrAdd),
      .slbi         (slbi),
      .btr          (btr),
      .branching    (branching),
      .halt         (halt),
      .aluOpr       (aluOpr),
      .bSrc         (bSrc),
      .regSrc       (regSrc),
      .branchCommand(branchCommand),
      .setCtrl      (setCtrl),
      .writeRegOut  (writeRegOut),
      .zeroExt      (zeroExt)
   );

   immediateExtender u_immediateExtender (
      .instruction  (instruction),
      .zeroExt      (zeroExt),
      .imm1         (imm1),
      .imm2         (imm2),
      .wordAlignJump(wordAlignJump)
   );

   regFile u_regFile (
      .clk      (clk),
      .rst      (rst),
      .read1Sel (instruction[10:8]),  // rs
      .read2Sel (instruction[7:5]),   // rt
      .writeSel (writeRegFromWb),
      .writeData(writeData),
      .writeEn  (regWrtFromWb),
      .read1Data(readData1),
      .read2Data(readData2)
   );

endmodule

/* decodeStageTb.sv */
// self-checking testbench for decodeStage, outputs sampled on the falling edge, fixed seed, no files
`timescale 1ns/1ps

module decodeStageTb
   import wiscIsaPkg::*;
   import decodeCtrlPkg::*;
;

   localparam int clkHalf     = 4;                   // 8 ns period
   localparam int resetCycles = 8;
   localparam int wrCycles    = 64;                  // random writeback phase
   localparam int repsPerOp   = 8;                   // instructions per opcode
   localparam int immCycles   = 200;                 // fully random instructions
   localparam int totalCycles = resetCycles + regCount + wrCycles + repsPerOp * 30
                                + immCycles + 8;     // 30 opcodes driven, one idle per test

   typedef struct packed {
      logic       regWrt, invA, invB, memWrt, memRd, aluJmp;
      logic       pcOrAdd, slbi, btr, branching, halt;
      aluOpr_t    aluOpr;
      bSrc_t      bSrc;
      regSrc_t    regSrc;
      branchCmd_t branchCommand;
      setCtrl_t   setCtrl;
      regIdx_t    writeReg;
      word_t      imm1, imm2, jmp;
   } expect_t;

   logic clk = 1'b0;
   logic rst, regWrtFromWb, checkOn;
   instr_t instruction;
   word_t writeData, readData1, readData2, imm1, imm2, wordAlignJump;
   regIdx_t writeRegFromWb, writeRegOut;
   aluOpr_t aluOpr;
   bSrc_t bSrc;
   regSrc_t regSrc;
   branchCmd_t branchCommand;
   setCtrl_t setCtrl;
   logic regWrt, invA, invB, memWrt, memRd, aluJmp, pcOrAdd, slbi, btr, branching, halt;

   word_t model [regCount];                          // expected register contents
   int errors = 0;
   int checks = 0;
   int errAtStart, chkAtStart;

   decodeStage u_decodeStage (.*);

   always #clkHalf clk = ~clk;

   // decode table and extension rules, grouped by the upper opcode bits
   function automatic expect_t refDecode(input instr_t ins);
      expect_t e;
      opcode_t op;
      logic [1:0] low;
      logic [1:0] fn;
      logic zx;
      regDst_t dst;
      e = '0;
      op = ins[15:11];
      low = op[1:0];                                 // variant within a group
      fn = ins[1:0];                                 // r-type funct
      zx = 1'b0;
      dst = dstRt;
      case (op[4:2])
         3'b000: e.halt = (op == opHalt);            // 00001..00011 leave all low
         3'b001: begin                               // j, jr, jal, jalr
            e.aluOpr = aluAdd;
            e.pcOrAdd = !low[0];
            e.aluJmp = low[0];
            e.bSrc = low[0] ? bSrcImm8 : bSrcReg;
            e.regWrt = low[1];
            dst = low[1] ? dstLink : dstRt;
         end
         3'b010: begin                               // addi subi xori andni
            e.regWrt = 1'b1;
            e.bSrc = bSrcImm5;
            e.regSrc = srcAlu;
            e.aluOpr = low[1] ? (low[0] ? aluAnd : aluXor) : aluAdd;
            e.invA = (low == 2'b01);
            e.invB = (low == 2'b11);
            zx = low[1];
         end
         3'b011: begin                               // branches
            e.branching = 1'b1;
            e.aluOpr = aluAdd;
            e.branchCommand = low;
            e.invB = low[1];                         // ltz and gez
         end
         3'b100: begin                               // st ld slbi stu
            e.aluOpr = (low == 2'b10) ? aluOr : aluAdd;
            e.bSrc = (low == 2'b10) ? bSrcImm8 : bSrcImm5;
            e.memWrt = (low == 2'b00) || (low == 2'b11);
            e.memRd = (low == 2'b01);
            e.regWrt = (low != 2'b00);
            e.regSrc = (low == 2'b01) ? srcMem : ((low == 2'b00) ? srcPc : srcAlu);
            e.slbi = (low == 2'b10);
            zx = (low == 2'b10);
            dst = low[1] ? dstRs : dstRt;
         end
         3'b101: begin                               // immediate shifts and rotates
            e.regWrt = 1'b1;
            e.bSrc = bSrcImm5;
            e.regSrc = srcAlu;
            e.aluOpr = {1'b0, low};
         end
         3'b110: begin
            e.regWrt = 1'b1;
            if (low == 2'b00) begin                  // lbi
               e.bSrc = bSrcImm8;
               e.regSrc = srcImm;
               dst = dstRs;
            end else begin                           // btr and r-type
               e.regSrc = srcAlu;
               dst = dstRd;
               e.btr = (low == 2'b01);
               if (low == 2'b11) begin
                  e.aluOpr = fn[1] ? (fn[0] ? aluAnd : aluXor) : aluAdd;
                  e.invA = (fn == 2'b01);
                  e.invB = (fn == 2'b11);
               end else if (low == 2'b10) begin
                  e.aluOpr = {1'b0, fn};
               end
            end
         end
         default: begin                              // compares
            e.regWrt = 1'b1;
            e.regSrc = srcAlu;
            e.setCtrl = {1'b1, low};
            dst = dstRd;
         end
      endcase
      e.writeReg = (dst == dstLink) ? linkReg : (dst == dstRs) ? ins[10:8] :
                   (dst == dstRd) ? ins[4:2] : ins[7:5];
      e.imm1 = zx ? {11'b0, ins[4:0]} : {{11{ins[4]}}, ins[4:0]};
      e.imm2 = zx ? {8'b0, ins[7:0]} : {{8{ins[7]}}, ins[7:0]};
      e.jmp = {{5{ins[10]}}, ins[10:0]};
      return e;
   endfunction

   task automatic fieldError(input string name, input logic [15:0] expVal,
                             input logic [15:0] gotVal);
      errors++;
      $display("error %s expected %h got %h instr %h", name, expVal, gotVal, instruction);
   endtask

   always @(posedge clk) begin                       // writes land at the edge, no bypass
      if (rst) begin
         for (int i = 0; i < regCount; i++) model[i] <= '0;
      end else if (regWrtFromWb) begin
         model[writeRegFromWb] <= writeData;
      end
   end

   always @(negedge clk) begin                       // outputs settled mid-cycle
      expect_t e;
      if (checkOn) begin
         e = refDecode(instruction);
         checks++;
         if (regWrt !== e.regWrt) fieldError("regWrt", e.regWrt, regWrt);
         if (invA !== e.invA) fieldError("invA", e.invA, invA);
         if (invB !== e.invB) fieldError("invB", e.invB, invB);
         if (memWrt !== e.memWrt) fieldError("memWrt", e.memWrt, memWrt);
         if (memRd !== e.memRd) fieldError("memRd", e.memRd, memRd);
         if (aluJmp !== e.aluJmp) fieldError("aluJmp", e.aluJmp, aluJmp);
         if (pcOrAdd !== e.pcOrAdd) fieldError("pcOrAdd", e.pcOrAdd, pcOrAdd);
         if (slbi !== e.slbi) fieldError("slbi", e.slbi, slbi);
         if (btr !== e.btr) fieldError("btr", e.btr, btr);
         if (branching !== e.branching) fieldError("branching", e.branching, branching);
         if (halt !== e.halt) fieldError("halt", e.halt, halt);
         if (aluOpr !== e.aluOpr) fieldError("aluOpr", e.aluOpr, aluOpr);
         if (bSrc !== e.bSrc) fieldError("bSrc", e.bSrc, bSrc);
         if (regSrc !== e.regSrc) fieldError("regSrc", e.regSrc, regSrc);
         if (branchCommand !== e.branchCommand)
            fieldError("branchCommand", e.branchCommand, branchCommand);
         if (setCtrl !== e.setCtrl) fieldError("setCtrl", e.setCtrl, setCtrl);
         if (writeRegOut !== e.writeReg) fieldError("writeRegOut", e.writeReg, writeRegOut);
         if (imm1 !== e.imm1) fieldError("imm1", e.imm1, imm1);
         if (imm2 !== e.imm2) fieldError("imm2", e.imm2, imm2);
         if (wordAlignJump !== e.jmp) fieldError("wordAlignJump", e.jmp, wordAlignJump);
         if (readData1 !== model[instruction[10:8]])
            fieldError("readData1", model[instruction[10:8]], readData1);
         if (readData2 !== model[instruction[7:5]])
            fieldError("readData2", model[instruction[7:5]], readData2);
      end
   end

   // one instruction per cycle, writeback often targets the rs being read
   task automatic driveCycle(input instr_t ins, input logic wbOn);
      regIdx_t sel;
      @(posedge clk);
      sel = ($urandom % 2) ? ins[10:8] : regIdx_t'($urandom);
      instruction <= ins;
      regWrtFromWb <= wbOn && ($urandom % 2 == 1);
      writeRegFromWb <= sel;
      writeData <= word_t'($urandom);
   endtask

   task automatic driveRange(input int first, input int last, input int reps);
      instr_t ins;
      for (int op = first; op <= last; op++) begin
         for (int r = 0; r < reps; r++) begin
            ins = instr_t'($urandom);
            ins[15:11] = op[4:0];
            ins[1:0] = r[1:0];                       // walks every funct
            driveCycle(ins, 1'b1);
         end
      end
   endtask

   task automatic startTest();
      errAtStart = errors;
      chkAtStart = checks;
   endtask

   task automatic endTest(input string name);
      @(posedge clk);                                // last instruction checked by now
      $display("%s: %0d checks, %0d errors", name, checks - chkAtStart, errors - errAtStart);
   endtask

   initial begin
      void'($urandom(32'h363c));
      rst = 1'b1;
      checkOn = 1'b0;
      instruction = '0;
      writeData = '0;
      writeRegFromWb = '0;
      regWrtFromWb = 1'b0;
      repeat (resetCycles) @(posedge clk);
      rst <= 1'b0;
      checkOn <= 1'b1;

      startTest();
      for (int i = 0; i < regCount; i++) begin       // every register reads zero
         driveCycle({opNop, i[2:0], i[2:0], 5'b0}, 1'b0);
      end
      for (int i = 0; i < wrCycles; i++) driveCycle(instr_t'($urandom), 1'b1);
      endTest("reset and writes");

      startTest();
      driveRange(5'b01000, 5'b01011, repsPerOp);
      driveRange(5'b10100, 5'b10111, repsPerOp);
      driveRange(5'b11010, 5'b11011, repsPerOp);
      endTest("alu instructions");

      startTest();
      driveRange(5'b10000, 5'b10011, repsPerOp);
      driveRange(5'b11000, 5'b11001, repsPerOp);
      endTest("memory instructions");

      startTest();
      driveRange(5'b00100, 5'b00111, repsPerOp);     // jumps
      driveRange(5'b01100, 5'b01111, repsPerOp);     // branches
      driveRange(5'b11100, 5'b11111, repsPerOp);     // compares
      endTest("control flow");

      startTest();
      for (int i = 0; i < immCycles; i++) driveCycle(instr_t'($urandom), 1'b1);
      endTest("immediates");

      startTest();
      driveRange(5'b00000, 5'b00001, repsPerOp);
      endTest("halt and nop");

      $display("totals: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

   initial begin                                     // watchdog
      #((totalCycles + 50) * 2 * clkHalf);
      $display("timeout: run did not finish within %0d cycles", totalCycles + 50);
      $display("TESTS FAILED");
      $finish;
   end

endmodule

/* files.f */
wiscIsaPkg.sv
decodeCtrlPkg.sv
controlDecoder.sv
immediateExtender.sv
regFile.sv
decodeStage.sv
decodeStageTb.sv

/* immediateExtender.sv */
// fixed field positions, zeroExt only affects imm1 and imm2 and the jump offset is always signed
`timescale 1ns/1ps

module immediateExtender
   import wiscIsaPkg::*;
(
   input  instr_t instruction,
   input  logic   zeroExt,            // high for xori, andni, slbi
   output word_t  imm1,
   output word_t  imm2,
   output word_t  wordAlignJump
);

   word_t signImm5;
   word_t zeroImm5;
   word_t signImm8;
   word_t zeroImm8;

   assign signImm5 = {{(wordWidth-5){instruction[4]}}, instruction[4:0]};
   assign zeroImm5 = {{(wordWidth-5){1'b0}}, instruction[4:0]};
   assign signImm8 = {{(wordWidth-8){instruction[7]}}, instruction[7:0]};
   assign zeroImm8 = {{(wordWidth-8){1'b0}}, instruction[7:0]};

   assign imm1 = zeroExt ? zeroImm5 : signImm5;           // i-format 1 immediate
   assign imm2 = zeroExt ? zeroImm8 : signImm8;           // i-format 2 / branch offset

   // j-format displacement for j and jal
   assign wordAlignJump = {{(wordWidth-11){instruction[10]}}, instruction[10:0]};

endmodule

/* regFile.sv */
// no write-to-read bypass, a read of the register being written returns the old value that cycle
`timescale 1ns/1ps

module regFile
   import wiscIsaPkg::*;
(
   input  logic    clk,
   input  logic    rst,               // sync, clears every register
   input  regIdx_t read1Sel,
   input  regIdx_t read2Sel,
   input  regIdx_t writeSel,
   input  word_t   writeData,
   input  logic    writeEn,           // from writeback, one write per clk
   output word_t   read1Data,
   output word_t   read2Data
);

   word_t regs [regCount];            // r0 is an ordinary register here

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData; // lands at the edge, visible next cycle
      end
   end

   assign read1Data = regs[read1Sel]; // rs port
   assign read2Data = regs[read2Sel]; // rt port

   // writeback must present a clean index and value whenever it writes
   wbClean: assert property (@(posedge clk) disable iff (rst)
      writeEn |-> !$isunknown({writeSel, writeData}))
      else $error("unknown write index or data from writeback");

endmodule

/* wiscIsaPkg.sv */
// isa-level types and opcodes only; the 00010 and 00011 slots carry no constant and decode as nops
package wiscIsaPkg;

   localparam int wordWidth = 16;                 // datapath and instruction width
   localparam int regCount  = 8;                  // architectural registers r0..r7

   typedef logic [wordWidth-1:0]        word_t;   // data word
   typedef logic [wordWidth-1:0]        instr_t;  // raw instruction
   typedef logic [$clog2(regCount)-1:0] regIdx_t; // register index field
   typedef logic [4:0]                  opcode_t; // instruction bits 15..11

   localparam regIdx_t linkReg = 3'd7;            // jal/jalr return address goes here

   localparam opcode_t opHalt  = 5'b00000;
   localparam opcode_t opNop   = 5'b00001;
   localparam opcode_t opJ     = 5'b00100;        // pc relative, 11-bit displacement
   localparam opcode_t opJr    = 5'b00101;        // rs + imm8
   localparam opcode_t opJal   = 5'b00110;
   localparam opcode_t opJalr  = 5'b00111;
   localparam opcode_t opAddi  = 5'b01000;
   localparam opcode_t opSubi  = 5'b01001;
   localparam opcode_t opXori  = 5'b01010;
   localparam opcode_t opAndni = 5'b01011;
   localparam opcode_t opBeqz  = 5'b01100;
   localparam opcode_t opBnez  = 5'b01101;
   localparam opcode_t opBltz  = 5'b01110;
   localparam opcode_t opBgez  = 5'b01111;
   localparam opcode_t opSt    = 5'b10000;
   localparam opcode_t opLd    = 5'b10001;
   localparam opcode_t opSlbi  = 5'b10010;
   localparam opcode_t opStu   = 5'b10011;
   localparam opcode_t opRoli  = 5'b10100;
   localparam opcode_t opSlli  = 5'b10101;
   localparam opcode_t opRori  = 5'b10110;
   localparam opcode_t opSrli  = 5'b10111;
   localparam opcode_t opLbi   = 5'b11000;
   localparam opcode_t opBtr   = 5'b11001;
   localparam opcode_t opShift = 5'b11010;        // r-type shifts, funct in bits 1..0
   localparam opcode_t opArith = 5'b11011;        // r-type add/sub/xor/andn, funct in bits 1..0
   localparam opcode_t opSeq   = 5'b11100;
   localparam opcode_t opSlt   = 5'b11101;
   localparam opcode_t opSle   = 5'b11110;
   localparam opcode_t opSco   = 5'b11111;

endpackage
